// File: bench/tb_cp0_vectors.svh
`ifndef TB_CP0_VECTORS_SVH
`define TB_CP0_VECTORS_SVH

typedef enum logic [3:0] {
    CHK_NONE, CHK_RDATA, CHK_ERET, CHK_EXL, CHK_TI, CHK_IE, CHK_IM, CHK_IP, CHK_EPC
} check_t;

// One cycle of stimulus and the output checked before the next rising edge
typedef struct packed {
    commit_req_t req;
    hw_int_t     irq;    // ext_int for this cycle
    check_t      chk;
    word_t       exp;
} vec_row_t;

vec_row_t vectors[$];

task automatic add_row(input commit_req_t req, input hw_int_t irq, input check_t chk,
                       input word_t exp);
    vectors.push_back('{req, irq, chk, exp});
endtask

task automatic add_idle(input int n);
    for (int k = 0; k < n; k++) begin
        add_row('0, 6'h00, CHK_NONE, 32'h0);
    end
endtask

task automatic load_vectors();
    commit_req_t bad_mtc0;

    // Reset values
    add_row(read_req(ADDR_COUNT), 6'h00, CHK_RDATA, 32'h0000_0000);
    add_row(read_req(ADDR_STATUS), 6'h00, CHK_RDATA, 32'h0040_0000);
    add_row(read_req(ADDR_COMPARE), 6'h00, CHK_RDATA, 32'h0001_55cc);
    add_row(read_req(ADDR_CAUSE), 6'h00, CHK_RDATA, 32'h0000_007c);   // ExcCode 31
    add_row(read_req(8'd8), 6'h00, CHK_RDATA, 32'h0000_0000);         // Unmapped
    add_row('0, 6'h00, CHK_EXL, 32'd0);
    add_row('0, 6'h00, CHK_TI, 32'd0);
    add_row('0, 6'h00, CHK_ERET, 32'd0);
    add_row('0, 6'h00, CHK_IE, 32'd0);
    add_row('0, 6'h00, CHK_IM, 32'h0000_0000);

    // mtc0 then mfc0
    add_row(write_req(ADDR_STATUS, 32'hffff_ffff), 6'h00, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_STATUS), 6'h00, CHK_RDATA, 32'h0040_ff03);
    add_row('0, 6'h00, CHK_IE, 32'd1);
    add_row('0, 6'h00, CHK_IM, 32'h0000_00ff);
    add_row(write_req(ADDR_STATUS, 32'h0040_0000), 6'h00, CHK_NONE, 32'h0);   // EXL back to 0
    add_row(read_req(ADDR_STATUS), 6'h00, CHK_RDATA, 32'h0040_0000);
    add_row(write_req(ADDR_EPC, 32'hbfc0_1234), 6'h00, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_EPC), 6'h00, CHK_RDATA, 32'hbfc0_1234);
    add_row(write_req(ADDR_COMPARE, 32'h8000_0000), 6'h00, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_COMPARE), 6'h00, CHK_RDATA, 32'h8000_0000);
    add_row(write_req(ADDR_COUNT, 32'h0000_1000), 6'h00, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_COUNT), 6'h00, CHK_RDATA, 32'h0000_1000);
    add_idle(9);
    add_row(read_req(ADDR_COUNT), 6'h00, CHK_RDATA, 32'h0000_1005);   // 10 cycles later
    add_row(write_req(ADDR_CAUSE, 32'h0000_0300), 6'h00, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_CAUSE), 6'h00, CHK_RDATA, 32'h0000_037c);

    // Syscall in a delay slot, then a nested Ov from a faulting mtc0
    add_row(exc_req(EXK_SYS, 1'b1, 32'h0040_0100, 32'h0), 6'h00, CHK_NONE, 32'h0);
    add_row('0, 6'h00, CHK_EXL, 32'd1);
    add_row(read_req(ADDR_EPC), 6'h00, CHK_RDATA, 32'h0040_00fc);
    add_row('0, 6'h00, CHK_EPC, 32'h0040_00fc);
    add_row(read_req(ADDR_CAUSE), 6'h00, CHK_RDATA, 32'h8000_0320);
    bad_mtc0      = write_req(ADDR_COMPARE, 32'h0000_0000);
    bad_mtc0.ex   = 1'b1;
    bad_mtc0.kind = EXK_OV;
    bad_mtc0.pc   = 32'h0040_0200;
    add_row(bad_mtc0, 6'h00, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_EPC), 6'h00, CHK_RDATA, 32'h0040_00fc);
    add_row(read_req(ADDR_CAUSE), 6'h00, CHK_RDATA, 32'h8000_0330);
    add_row(read_req(ADDR_COMPARE), 6'h00, CHK_RDATA, 32'h8000_0000);
    add_row(eret_req(), 6'h00, CHK_ERET, 32'd1);
    add_row('0, 6'h00, CHK_EXL, 32'd0);

    // Address errors
    add_row(exc_req(EXK_ADEL, 1'b0, 32'h0040_0302, 32'h1234_5678), 6'h00, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_BADVADDR), 6'h00, CHK_RDATA, 32'h0040_0302);
    add_row(exc_req(EXK_ADES, 1'b0, 32'h0040_0400, 32'h1000_0003), 6'h00, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_BADVADDR), 6'h00, CHK_RDATA, 32'h1000_0003);
    add_row(eret_req(), 6'h00, CHK_ERET, 32'd1);

    // Timer interrupt
    add_row(write_req(ADDR_COUNT, 32'h7fff_ffff), 6'h00, CHK_NONE, 32'h0);
    add_idle(4);
    add_row('0, 6'h00, CHK_TI, 32'd1);
    add_row(read_req(ADDR_CAUSE), 6'h00, CHK_RDATA, 32'h4000_8314);   // TI and IP7 set
    add_row(write_req(ADDR_COMPARE, 32'hffff_0000), 6'h00, CHK_NONE, 32'h0);
    add_row('0, 6'h00, CHK_TI, 32'd0);

    // Hardware and software interrupt bits
    add_row(write_req(ADDR_CAUSE, 32'h0000_0200), 6'b100001, CHK_NONE, 32'h0);
    add_row(read_req(ADDR_CAUSE), 6'b100001, CHK_RDATA, 32'h0000_8614);
    add_row('0, 6'b100001, CHK_IP, 32'h0000_0086);
endtask

`endif

// File: bench/tb_cp0.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cp0 import cp0_pkg::*; ();

    localparam int RESET_CYCLES = 16;

    logic        clk;
    logic        reset;
    commit_req_t commit;
    hw_int_t     ext_int;
    word_t       rdata;
    logic        eret_flush;
    cp0_state_t  state;
    int          cycles = 0;

    cp0_top dut (
        .clk        (clk),
        .reset      (reset),
        .commit     (commit),
        .ext_int    (ext_int),
        .rdata      (rdata),
        .eret_flush (eret_flush),
        .state      (state)
    );

    // mfc0 is any valid request that is not an mtc0
    function automatic commit_req_t read_req(input cp0_addr_t addr);
        commit_req_t req;
        req       = '0;
        req.valid = 1'b1;
        req.addr  = addr;
        return req;
    endfunction

    function automatic commit_req_t write_req(input cp0_addr_t addr, input word_t data);
        commit_req_t req;
        req         = read_req(addr);
        req.is_mtc0 = 1'b1;
        req.wdata   = data;
        return req;
    endfunction

    function automatic commit_req_t exc_req(input exc_kind_t kind, input logic bd,
                                            input word_t pc, input word_t data);
        commit_req_t req;
        req       = '0;
        req.valid = 1'b1;
        req.ex    = 1'b1;
        req.bd    = bd;
        req.kind  = kind;
        req.pc    = pc;
        req.wdata = data;   // Data address for AdES and AdEL
        return req;
    endfunction

    function automatic commit_req_t eret_req();
        commit_req_t req;
        req         = '0;
        req.valid   = 1'b1;
        req.is_eret = 1'b1;
        return req;
    endfunction

    `include "tb_cp0_vectors.svh"

    task automatic compare_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > RESET_CYCLES + vectors.size() + 50) begin
            $display("timeout: the table did not finish within %0d cycles", cycles - 1);
            $display("*** FAILED ***");
            $fatal(1, "run ended by the cycle limit");
        end
    end

    initial begin
        reset   = 1'b1;
        commit  = '0;
        ext_int = '0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < vectors.size(); i++) begin
            commit  = vectors[i].req;
            ext_int = vectors[i].irq;
            #2;   // Midway to the rising edge
            case (vectors[i].chk)
                CHK_RDATA: compare_value("rdata", rdata, vectors[i].exp);
                CHK_ERET:  compare_value("eret_flush", {31'b0, eret_flush}, vectors[i].exp);
                CHK_EXL:   compare_value("state.exl", {31'b0, state.exl}, vectors[i].exp);
                CHK_TI:    compare_value("state.ti", {31'b0, state.ti}, vectors[i].exp);
                CHK_IE:    compare_value("state.ie", {31'b0, state.ie}, vectors[i].exp);
                CHK_IM:    compare_value("state.im", {24'b0, state.im}, vectors[i].exp);
                CHK_IP:    compare_value("state.ip", {24'b0, state.ip}, vectors[i].exp);
                CHK_EPC:   compare_value("state.epc", state.epc, vectors[i].exp);
                default:   ;
            endcase
            @(negedge clk);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/cp0_commit.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_commit import cp0_pkg::*; (
    input  commit_req_t commit,
    input  logic        exl,
    output cp0_wen_t    wen,
    output logic        ex_first,
    output logic        eret_flush
);

    logic mtc0_we;
    logic ex_take;

    // An instruction that faulted never updates a register
    assign mtc0_we = commit.valid && commit.is_mtc0 && !commit.ex;
    assign ex_take = commit.valid && commit.ex;

    always_comb begin
        wen         = '0;
        wen.status  = mtc0_we && (commit.addr == ADDR_STATUS);
        wen.cause   = mtc0_we && (commit.addr == ADDR_CAUSE);
        wen.count   = mtc0_we && (commit.addr == ADDR_COUNT);
        wen.compare = mtc0_we && (commit.addr == ADDR_COMPARE);
        wen.epc     = mtc0_we && (commit.addr == ADDR_EPC);
        wen.exc     = ex_take;
    end

    // Nested exceptions keep EPC and BD of the outer one
    assign ex_first = ex_take && !exl;

    assign eret_flush = commit.valid && commit.is_eret && !commit.ex;

endmodule

`default_nettype wire

// File: design/cp0_exc_addr.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_exc_addr import cp0_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  commit_req_t commit,
    input  cp0_wen_t    wen,
    input  logic        ex_first,
    output word_t       epc,
    output word_t       badvaddr
);

    logic pc_misaligned;

    assign pc_misaligned = (commit.pc[1:0] != 2'b00);

    // EPC points at the branch when the fault is in its delay slot
    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (ex_first) begin
            epc <= commit.bd ? commit.pc - 32'd4 : commit.pc;
        end else if (wen.epc) begin
            epc <= commit.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr <= '0;
        end else if (wen.exc) begin
            if (commit.kind == EXK_ADES) begin
                badvaddr <= commit.wdata;   // Store address
            end else if (commit.kind == EXK_ADEL) begin
                // Fetch fault if the pc itself is bad, load fault otherwise
                badvaddr <= pc_misaligned ? commit.pc : commit.wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    typedef logic [31:0] word_t;       // Data word or address
    typedef logic [7:0]  cp0_addr_t;   // {rd, sel}
    typedef logic [4:0]  exc_kind_t;   // Pipeline exception kind
    typedef logic [4:0]  exc_code_t;   // Architectural ExcCode
    typedef logic [7:0]  irq_t;        // Pending or mask bits
    typedef logic [5:0]  hw_int_t;     // External interrupt lines

    localparam cp0_addr_t ADDR_BADVADDR = 8'd64;   // rd 8, sel 0
    localparam cp0_addr_t ADDR_COUNT    = 8'd72;   // rd 9, sel 0
    localparam cp0_addr_t ADDR_COMPARE  = 8'd88;   // rd 11, sel 0
    localparam cp0_addr_t ADDR_STATUS   = 8'd96;   // rd 12, sel 0
    localparam cp0_addr_t ADDR_CAUSE    = 8'd104;  // rd 13, sel 0
    localparam cp0_addr_t ADDR_EPC      = 8'd112;  // rd 14, sel 0

    localparam exc_kind_t EXK_NONE = 5'd0;
    localparam exc_kind_t EXK_INT  = 5'd1;
    localparam exc_kind_t EXK_ADEL = 5'd2;
    localparam exc_kind_t EXK_ADES = 5'd3;
    localparam exc_kind_t EXK_SYS  = 5'd4;
    localparam exc_kind_t EXK_BP   = 5'd5;
    localparam exc_kind_t EXK_RI   = 5'd6;
    localparam exc_kind_t EXK_OV   = 5'd7;
    localparam exc_kind_t EXK_TRAP = 5'd8;

    localparam exc_code_t CODE_INT  = 5'd0;
    localparam exc_code_t CODE_ADEL = 5'd4;
    localparam exc_code_t CODE_ADES = 5'd5;
    localparam exc_code_t CODE_SYS  = 5'd8;
    localparam exc_code_t CODE_BP   = 5'd9;
    localparam exc_code_t CODE_RI   = 5'd10;
    localparam exc_code_t CODE_OV   = 5'd12;
    localparam exc_code_t CODE_TR   = 5'd13;
    localparam exc_code_t CODE_NONE = 5'd31;   // Nothing recorded yet

    // One instruction leaving the commit stage
    typedef struct packed {
        logic      valid;
        logic      is_mtc0;
        logic      is_eret;
        logic      ex;        // Exception reported for this instruction
        logic      bd;        // Sits in a branch delay slot
        exc_kind_t kind;
        cp0_addr_t addr;      // mtc0 or mfc0 target
        word_t     pc;
        word_t     wdata;     // ALU result, mtc0 data or data address
    } commit_req_t;

    typedef struct packed {
        logic status;
        logic cause;
        logic count;
        logic compare;
        logic epc;
        logic exc;            // Exception accepted this cycle
    } cp0_wen_t;

    // Values the pipeline needs for redirect and interrupt decision
    typedef struct packed {
        word_t epc;
        logic  ie;
        logic  exl;
        irq_t  im;
        irq_t  ip;
        logic  ti;
    } cp0_state_t;

endpackage

`default_nettype wire

// File: design/cp0_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_read_mux import cp0_pkg::*; (
    input  cp0_addr_t addr,
    input  word_t     count,
    input  word_t     compare,
    input  word_t     epc,
    input  word_t     badvaddr,
    input  logic      ie,
    input  logic      exl,
    input  logic      bev,
    input  irq_t      im,
    input  irq_t      ip,
    input  logic      bd,
    input  logic      ti,
    input  exc_code_t exc_code,
    output word_t     rdata
);

    word_t status_word;
    word_t cause_word;

    assign status_word = {9'b0, bev, 6'b0, im, 6'b0, exl, ie};
    assign cause_word  = {bd, ti, 14'b0, ip, 1'b0, exc_code, 2'b00};

    always_comb begin
        case (addr)
            ADDR_BADVADDR: rdata = badvaddr;
            ADDR_COUNT:    rdata = count;
            ADDR_COMPARE:  rdata = compare;
            ADDR_STATUS:   rdata = status_word;
            ADDR_CAUSE:    rdata = cause_word;
            ADDR_EPC:      rdata = epc;
            default:       rdata = '0;   // Unmapped
        endcase
    end

endmodule

`default_nettype wire

// File: design/cp0_status_cause.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_status_cause import cp0_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  commit_req_t commit,
    input  cp0_wen_t    wen,
    input  logic        ex_first,
    input  logic        eret_flush,
    input  logic        ti,
    input  hw_int_t     ext_int,
    output logic        ie,
    output logic        exl,
    output logic        bev,
    output irq_t        im,
    output irq_t        ip,
    output logic        bd,
    output exc_code_t   exc_code
);

    exc_code_t code_next;

    // Status
    always_ff @(posedge clk) begin
        if (reset) begin
            ie  <= 1'b0;
            bev <= 1'b1;    // Boot vectors after reset
            im  <= '0;
        end else if (wen.status) begin
            ie  <= commit.wdata[0];
            bev <= commit.wdata[22];
            im  <= commit.wdata[15:8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (wen.exc) begin
            exl <= 1'b1;
        end else if (eret_flush) begin
            exl <= 1'b0;
        end else if (wen.status) begin
            exl <= commit.wdata[1];
        end
    end

    // Cause
    always_ff @(posedge clk) begin
        if (reset) begin
            bd <= 1'b0;
        end else if (ex_first) begin
            bd <= commit.bd;
        end
    end

    always_comb begin
        case (commit.kind)
            EXK_INT:  code_next = CODE_INT;
            EXK_ADEL: code_next = CODE_ADEL;
            EXK_ADES: code_next = CODE_ADES;
            EXK_SYS:  code_next = CODE_SYS;
            EXK_BP:   code_next = CODE_BP;
            EXK_RI:   code_next = CODE_RI;
            EXK_OV:   code_next = CODE_OV;
            EXK_TRAP: code_next = CODE_TR;
            default:  code_next = CODE_NONE;   // Includes EXK_NONE
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_code <= CODE_NONE;
        end else if (wen.exc) begin
            exc_code <= code_next;   // Updated even when nested
        end
    end

    // Hardware lines are sampled every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ip[7:2] <= '0;
        end else begin
            ip[7]   <= ext_int[5] | ti;   // Timer shares IP7
            ip[6:2] <= ext_int[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip[1:0] <= '0;
        end else if (wen.cause) begin
            ip[1:0] <= commit.wdata[9:8];   // Software interrupts
        end
    end

endmodule

`default_nettype wire

// File: design/cp0_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_timer import cp0_pkg::*; #(
    parameter word_t COMPARE_RESET = 32'h0001_55cc
) (
    input  logic     clk,
    input  logic     reset,
    input  cp0_wen_t wen,
    input  word_t    wdata,
    output word_t    count,
    output word_t    compare,
    output logic     ti
);

    logic tick;   // High on every second cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (wen.count) begin
            count <= wdata;   // Write wins over the increment
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= COMPARE_RESET;
        end else if (wen.compare) begin
            compare <= wdata;
        end
    end

    // Sticky until software rewrites Compare
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (wen.compare) begin
            ti <= 1'b0;
        end else if (count == compare) begin
            ti <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/cp0_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_top import cp0_pkg::*; #(
    parameter word_t COMPARE_RESET = 32'h0001_55cc
) (
    input  logic        clk,
    input  logic        reset,
    input  commit_req_t commit,
    input  hw_int_t     ext_int,
    output word_t       rdata,
    output logic        eret_flush,
    output cp0_state_t  state
);

    cp0_wen_t  wen;
    logic      ex_first;
    logic      ie;
    logic      exl;
    logic      bev;
    irq_t      im;
    irq_t      ip;
    logic      bd;
    logic      ti;
    exc_code_t exc_code;
    word_t     count;
    word_t     compare;
    word_t     epc;
    word_t     badvaddr;

    cp0_commit u_commit (
        .commit     (commit),
        .exl        (exl),
        .wen        (wen),
        .ex_first   (ex_first),
        .eret_flush (eret_flush)
    );

    cp0_status_cause u_status_cause (
        .clk        (clk),
        .reset      (reset),
        .commit     (commit),
        .wen        (wen),
        .ex_first   (ex_first),
        .eret_flush (eret_flush),
        .ti         (ti),
        .ext_int    (ext_int),
        .ie         (ie),
        .exl        (exl),
        .bev        (bev),
        .im         (im),
        .ip         (ip),
        .bd         (bd),
        .exc_code   (exc_code)
    );

    cp0_timer #(
        .COMPARE_RESET (COMPARE_RESET)
    ) u_timer (
        .clk     (clk),
        .reset   (reset),
        .wen     (wen),
        .wdata   (commit.wdata),
        .count   (count),
        .compare (compare),
        .ti      (ti)
    );

    cp0_exc_addr u_exc_addr (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit),
        .wen      (wen),
        .ex_first (ex_first),
        .epc      (epc),
        .badvaddr (badvaddr)
    );

    cp0_read_mux u_read_mux (
        .addr     (commit.addr),
        .count    (count),
        .compare  (compare),
        .epc      (epc),
        .badvaddr (badvaddr),
        .ie       (ie),
        .exl      (exl),
        .bev      (bev),
        .im       (im),
        .ip       (ip),
        .bd       (bd),
        .ti       (ti),
        .exc_code (exc_code),
        .rdata    (rdata)
    );

    assign state.epc = epc;
    assign state.ie  = ie;
    assign state.exl = exl;
    assign state.im  = im;
    assign state.ip  = ip;
    assign state.ti  = ti;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench and look for the pass line in the log
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log=sim.log

verilator --binary --timing --top-module tb_cp0 -f sim.f -Mdir "$build_dir" -o tb_cp0
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/tb_cp0" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** PASSED ***' "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

// File: sim.f
+incdir+bench
design/cp0_pkg.sv
design/cp0_commit.sv
design/cp0_status_cause.sv
design/cp0_timer.sv
design/cp0_exc_addr.sv
design/cp0_read_mux.sv
design/cp0_top.sv
bench/tb_cp0.sv
